// ==== Makefile ====
# Verilator build and run of the packet transmitter testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f packet_tx.f \
		--top-module tb_packet_tx -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_packet_tx); \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== desc_fifo.sv ====
/*
descriptor fifo between scheduler and serializer
returns one credit per entry read out
*/
`timescale 1ns/1ps
`default_nettype none
module desc_fifo import packet_pkg::*; #(
	parameter int fifo_depth = 4
) (
	input wire clk125MHz,
	input wire RST,
	send_desc_if.buffer desc_port,
	input wire pop, // only while fifo_nonempty
	output logic fifo_nonempty,
	output send_desc_t head
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	send_desc_t mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] occupancy;
	logic push;

	// wraps at any depth, not just powers of two
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign push = desc_port.desc_valid; // credits mean there is always room
	assign fifo_nonempty = (occupancy != '0);
	assign head = mem[rd_ptr]; // first-word fall through

	always_ff @(posedge clk125MHz) begin
		if (push) begin
			mem[wr_ptr] <= desc_port.desc;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			desc_port.credit_return <= 1'b0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy; // simultaneous push and pop
			endcase
			desc_port.credit_return <= pop; // one cycle after the read
		end
	end

endmodule
`default_nettype wire

// ==== frame_serializer.sv ====
/*
frame serializer: takes one descriptor per frame and sends the
4 header bytes then a synthetic payload under valid/ready
*/
`timescale 1ns/1ps
`default_nettype none
module frame_serializer import packet_pkg::*; #(
	parameter int payload_bytes = 8
) (
	input wire clk125MHz,
	input wire RST,
	input wire fifo_nonempty,
	input wire send_desc_t head,
	output logic pop,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic tx_last,
	input wire tx_ready
);

	localparam int frame_len = hdr_bytes + payload_bytes;
	localparam int idx_w = $clog2(frame_len);
	localparam logic [idx_w-1:0] last_idx = idx_w'(frame_len - 1);
	localparam logic [idx_w-1:0] pay_start = idx_w'(hdr_bytes);

	frame_hdr_u hdr_q; // loaded as desc, read out as bytes
	logic [idx_w-1:0] byte_idx; // byte on tx_data right now
	logic [7:0] pay_k; // payload byte number
	logic accept;

	assign accept = tx_valid && tx_ready;
	assign tx_last = tx_valid && (byte_idx == last_idx);

	// idle, or last byte leaving this cycle, so frames run back to back
	assign pop = fifo_nonempty && (!tx_valid || (accept && tx_last));

	assign pay_k = 8'(byte_idx - pay_start);

	// output byte from registers only, so it holds while stalled
	always_comb begin
		if (byte_idx < pay_start) begin
			tx_data = hdr_q.bytes[byte_idx[1:0]]; // seg hi, seg lo, txid, aux
		end else begin
			tx_data = hdr_q.desc.segment_num[7:0] + pay_k; // ramp from seg low byte
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (pop) begin
			hdr_q.desc <= head;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			tx_valid <= 1'b0;
			byte_idx <= '0;
		end else if (pop) begin
			tx_valid <= 1'b1; // first header byte next cycle
			byte_idx <= '0;
		end else if (accept) begin
			if (tx_last) begin
				tx_valid <= 1'b0; // nothing queued
			end else begin
				byte_idx <= byte_idx + 1'b1; // advance on transfer only
			end
		end
	end

endmodule
`default_nettype wire

// ==== max_count_gen.sv ====
/*
switch word decode: send gap in cycles, segments per round
and number of copies per segment
*/
`timescale 1ns/1ps
`default_nettype none
module max_count_gen import packet_pkg::*; #(
	parameter int gap_unit = 16 // cycles per speed step
) (
	input wire switch_cfg_t switches,
	output logic [gap_w-1:0] max_count, // timer compare value
	output logic [seg_w-1:0] segment_num_max, // segments per round
	output logic [txid_w-1:0] redundancy // highest txid
);

	logic [4:0] speed_steps; // 1..16

	// speed 0 still gives one unit of gap
	assign speed_steps = {1'b0, switches.speed} + 5'd1;

	// gap_unit is fixed at build time, so this folds to shifts and adds
	assign max_count = gap_w'(speed_steps * gap_w'(gap_unit));

	assign segment_num_max = seg_count(switches.fragment); // 2 << fragment
	assign redundancy = copy_count(switches.redundancy); // field + 1

endmodule
`default_nettype wire

// ==== packet_pkg.sv ====
/*
packet tx shared definitions: field widths, descriptor and header
layouts, switch word fields and their decode helpers
*/
`default_nettype none
package packet_pkg;

	localparam int seg_w = 16; // segment number
	localparam int txid_w = 8; // transmission id, 1..redundancy
	localparam int aux_w = 8;
	localparam int gap_w = 28; // send gap counter
	localparam int hdr_bytes = 4; // header length on the wire

	// one send request, scheduler -> fifo -> serializer
	typedef struct packed {
		logic [seg_w-1:0] segment_num;
		logic [txid_w-1:0] txid;
		logic [aux_w-1:0] aux;
	} send_desc_t;

	// same 32 bits, loaded as a descriptor, shifted out as bytes
	// bytes[0] is the msb, so seg high byte goes first
	typedef union packed {
		send_desc_t desc;
		logic [0:hdr_bytes-1][7:0] bytes;
	} frame_hdr_u;

	// dip switch word layout
	typedef struct packed {
		logic [1:0] fragment; // segments = 2 << fragment
		logic [1:0] redundancy; // copies = field + 1
		logic [3:0] speed; // gap = (speed + 1) * gap_unit
	} switch_cfg_t;

	// segments per round: 2, 4, 8 or 16
	function automatic logic [seg_w-1:0] seg_count(input logic [1:0] fragment);
		return seg_w'(2) << fragment;
	endfunction

	// copies of each segment per round, 1..4
	function automatic logic [txid_w-1:0] copy_count(input logic [1:0] redundancy);
		return txid_w'(redundancy) + 1'b1;
	endfunction

endpackage
`default_nettype wire

// ==== packet_tx.f ====
packet_pkg.sv
send_desc_if.sv
max_count_gen.sv
send_control.sv
desc_fifo.sv
frame_serializer.sv
packet_tx_top.sv
tb_packet_tx.sv

// ==== packet_tx_top.sv ====
/*
paced redundant packet transmitter
scheduler -> descriptor fifo -> frame serializer
*/
`timescale 1ns/1ps
`default_nettype none
module packet_tx_top import packet_pkg::*; #(
	parameter int fifo_depth = 4, // also the scheduler's credits
	parameter int gap_unit = 16, // cycles per speed step
	parameter int payload_bytes = 8
) (
	input wire clk125MHz,
	input wire RST,
	input wire [7:0] switches, // [7:6] fragment, [5:4] redundancy, [3:0] speed
	output wire [7:0] tx_data,
	output wire tx_valid,
	output wire tx_last,
	input wire tx_ready
);

	send_desc_if desc_if ();

	// fifo head to serializer
	wire fifo_nonempty;
	wire send_desc_t head;
	wire pop;

	send_control #(
		.fifo_depth(fifo_depth),
		.gap_unit(gap_unit)
	) send_control_i (
		.clk125MHz(clk125MHz),
		.RST(RST),
		.switches(switches),
		.desc_port(desc_if.producer)
	);

	desc_fifo #(
		.fifo_depth(fifo_depth)
	) desc_fifo_i (
		.clk125MHz(clk125MHz),
		.RST(RST),
		.desc_port(desc_if.buffer),
		.pop(pop),
		.fifo_nonempty(fifo_nonempty),
		.head(head)
	);

	frame_serializer #(
		.payload_bytes(payload_bytes)
	) frame_serializer_i (
		.clk125MHz(clk125MHz),
		.RST(RST),
		.fifo_nonempty(fifo_nonempty),
		.head(head),
		.pop(pop),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.tx_ready(tx_ready)
	);

endmodule
`default_nettype wire

// ==== send_control.sv ====
/*
send scheduler: walks segment and txid over a round, paces
descriptors with a gap timer and spends fifo credits
*/
`timescale 1ns/1ps
`default_nettype none
module send_control import packet_pkg::*; #(
	parameter int fifo_depth = 4, // initial credits
	parameter int gap_unit = 16
) (
	input wire clk125MHz,
	input wire RST,
	input wire [7:0] switches, // [7:6] fragment, [5:4] redundancy, [3:0] speed
	send_desc_if.producer desc_port
);

	localparam int cred_w = $clog2(fifo_depth + 1);

	localparam logic st_load = 1'b0; // take switch config, restart walk
	localparam logic st_run = 1'b1; // pace and issue

	// live decode of the switches
	logic [gap_w-1:0] max_count;
	logic [seg_w-1:0] segment_num_max;
	logic [txid_w-1:0] redundancy;

	// config held for a whole round
	logic [gap_w-1:0] max_count_q;
	logic [seg_w-1:0] seg_max_q;
	logic [txid_w-1:0] red_q;

	logic state;
	logic [gap_w-1:0] gap_cnt;
	logic [cred_w-1:0] credits; // free fifo entries as seen from here
	logic [seg_w-1:0] segment_num;
	logic [txid_w-1:0] txid;
	logic [aux_w-1:0] aux_base; // advances by seg count per round

	logic has_credit;
	logic timer_done;
	logic issue;
	logic last_seg;
	logic last_txid;

	max_count_gen #(
		.gap_unit(gap_unit)
	) max_count_gen_i (
		.switches(switch_cfg_t'(switches)),
		.max_count(max_count),
		.segment_num_max(segment_num_max),
		.redundancy(redundancy)
	);

	assign has_credit = (credits != '0);
	assign timer_done = (gap_cnt >= max_count_q); // >= covers a smaller gap after reload
	assign issue = (state == st_run) && timer_done && has_credit;
	assign last_seg = (segment_num == seg_max_q - 1'b1);
	assign last_txid = (txid == red_q);

	// descriptor straight from the walk registers
	assign desc_port.desc_valid = issue;
	assign desc_port.desc = '{
		segment_num: segment_num,
		txid: txid,
		aux: aux_base + segment_num[aux_w-1:0] // wraps at 8 bits
	};

	// gap timer, frozen without credits
	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			gap_cnt <= '0;
		end else if (issue) begin
			gap_cnt <= '0;
		end else if (state == st_run && has_credit && !timer_done) begin
			gap_cnt <= gap_cnt + 1'b1;
		end
	end

	// credit counter
	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			credits <= cred_w'(fifo_depth); // fifo starts empty
		end else begin
			case ({desc_port.credit_return, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits; // both or neither
			endcase
		end
	end

	// segment / txid walk
	always_ff @(posedge clk125MHz) begin
		if (RST) begin
			state <= st_load;
			segment_num <= '0;
			txid <= txid_w'(1);
			aux_base <= '0;
			max_count_q <= '0;
			seg_max_q <= '0;
			red_q <= '0;
		end else begin
			case (state)
				st_load: begin
					// switches only take effect here
					max_count_q <= max_count;
					seg_max_q <= segment_num_max;
					red_q <= redundancy;
					segment_num <= '0;
					txid <= txid_w'(1);
					state <= st_run;
				end
				st_run: begin
					if (issue) begin
						if (!last_seg) begin
							segment_num <= segment_num + 1'b1;
						end else begin
							segment_num <= '0; // next copy or next round
							if (!last_txid) begin
								txid <= txid + 1'b1;
							end else begin
								// round done
								aux_base <= aux_base + seg_max_q[aux_w-1:0];
								state <= st_load;
							end
						end
					end
				end
			endcase
		end
	end

endmodule
`default_nettype wire

// ==== send_desc_if.sv ====
/*
descriptor link from scheduler to fifo
credit based, no ready: a spent credit guarantees a free entry
*/
`timescale 1ns/1ps
`default_nettype none
interface send_desc_if import packet_pkg::*; ();

	logic desc_valid; // one cycle per spent credit
	send_desc_t desc; // valid with desc_valid only
	logic credit_return; // pulse per entry leaving the fifo

	// scheduler side
	modport producer (
		output desc_valid,
		output desc,
		input credit_return
	);

	// fifo side
	modport buffer (
		input desc_valid,
		input desc,
		output credit_return
	);

endinterface
`default_nettype wire

// ==== tb_packet_tx.sv ====
/*
table driven packet tx testbench checking the segment / txid / aux
walk against a model under random tx_ready stalls
*/
`timescale 1ns/1ps
`default_nettype none
module tb_packet_tx import packet_pkg::*; ();

	localparam int gap_unit = 2; // short gaps keep runs brief
	localparam int pay_len = 8; // dut default payload_bytes
	localparam int frame_len = 4 + pay_len;
	localparam int n_tests = 6;

	logic clk125MHz = 1'b0;
	logic RST;
	logic [7:0] switches;
	logic tx_ready = 1'b1;
	wire [7:0] tx_data;
	wire tx_valid;
	wire tx_last;

	// stimulus table with one row per run
	string test_tab [n_tests];
	logic [7:0] switch_tab [n_tests];
	int frames_tab [n_tests];
	bit bp_tab [n_tests];

	string test_name; // row being run
	bit bp_on; // random tx_ready when set
	logic [31:0] rng = 32'd96101;
	int errors;
	int checks;
	longint cycle_count = 0;
	longint cycle_limit;

	// model walk state
	logic [15:0] m_seg;
	logic [7:0] m_txid;
	logic [7:0] m_aux_base;
	logic [15:0] m_seg_cnt; // segments per round
	logic [7:0] m_copies; // highest txid

	packet_tx_top #(
		.gap_unit(gap_unit)
	) dut0 (
		.clk125MHz(clk125MHz),
		.RST(RST),
		.switches(switches),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.tx_ready(tx_ready)
	);

	always #4 clk125MHz = ~clk125MHz; // 8 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sink ready changes 1 ns after the edge
	always @(posedge clk125MHz) begin
		#1;
		if (bp_on) begin
			rng = xorshift32(rng);
			tx_ready = rng[7]; // about half the cycles stalled
		end else begin
			tx_ready = 1'b1;
		end
	end

	// cycle budget for the whole table
	always @(posedge clk125MHz) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: table not finished within %0d cycles, run stopped", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic fill_table();
		test_tab[0] = "two_seg_single"; // 4 rounds of 2
		switch_tab[0] = 8'h00;
		frames_tab[0] = 8;
		bp_tab[0] = 1'b0;
		test_tab[1] = "four_seg_triple";
		switch_tab[1] = 8'h61;
		frames_tab[1] = 40;
		bp_tab[1] = 1'b0;
		test_tab[2] = "eight_seg_double_stall";
		switch_tab[2] = 8'h90;
		frames_tab[2] = 50;
		bp_tab[2] = 1'b1;
		test_tab[3] = "sixteen_seg_quad_stall";
		switch_tab[3] = 8'hF3;
		frames_tab[3] = 70;
		bp_tab[3] = 1'b1;
		test_tab[4] = "two_seg_quad_stall";
		switch_tab[4] = 8'h30;
		frames_tab[4] = 36;
		bp_tab[4] = 1'b1;
		test_tab[5] = "aux_wrap"; // 18 rounds of 16 so the base passes 255
		switch_tab[5] = 8'hC0;
		frames_tab[5] = 290;
		bp_tab[5] = 1'b0;
	endtask

	task automatic check_value(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s %s: expected 0x%0h, actual 0x%0h",
				test_name, field, expected, actual);
		end
	endtask

	// fresh round from the switch fields
	task automatic model_start(input logic [7:0] sw);
		switch_cfg_t cfg;
		cfg = switch_cfg_t'(sw);
		m_seg_cnt = 16'd1 << (int'(cfg.fragment) + 1); // 2 ** (fragment + 1)
		m_copies = {6'd0, cfg.redundancy} + 8'd1;
		m_seg = '0;
		m_txid = 8'd1;
		m_aux_base = '0;
	endtask

	// segments inner and txid outer with the base moving per round
	task automatic model_advance();
		if (m_seg != m_seg_cnt - 16'd1) begin
			m_seg = m_seg + 16'd1;
		end else begin
			m_seg = '0;
			if (m_txid != m_copies) begin
				m_txid = m_txid + 8'd1;
			end else begin
				m_txid = 8'd1;
				m_aux_base = m_aux_base + m_seg_cnt[7:0]; // wraps at 8 bits
			end
		end
	endtask

	function automatic logic [7:0] expected_byte(input int idx);
		case (idx)
			0: return m_seg[15:8];
			1: return m_seg[7:0];
			2: return m_txid;
			3: return m_aux_base + m_seg[7:0];
			default: return m_seg[7:0] + 8'(idx - 4); // payload ramp
		endcase
	endfunction

	task automatic apply_reset(input logic [7:0] sw, input bit bp);
		@(posedge clk125MHz);
		#1;
		RST = 1'b1;
		switches = sw;
		repeat (4) @(posedge clk125MHz);
		#1;
		RST = 1'b0;
		@(negedge clk125MHz);
		bp_on = bp;
		check_value("tx_valid after reset", 32'd0, 32'(tx_valid));
		check_value("tx_last after reset", 32'd0, 32'(tx_last));
	endtask

	// one frame sampled mid cycle and counted on valid && ready
	task automatic check_frame(input int frame_no);
		int idx;
		string field;
		idx = 0;
		while (idx < frame_len) begin
			@(negedge clk125MHz);
			if (tx_valid && tx_ready) begin
				field = $sformatf("frame %0d byte %0d", frame_no, idx);
				check_value(field, 32'(expected_byte(idx)), 32'(tx_data));
				check_value({field, " last"}, 32'(idx == frame_len - 1), 32'(tx_last));
				idx++;
			end
		end
	endtask

	initial begin
		int r;
		int f;
		int gap;
		RST = 1'b1;
		switches = 8'h00;
		bp_on = 1'b0;
		errors = 0;
		checks = 0;
		fill_table();
		cycle_limit = 0;
		for (r = 0; r < n_tests; r++) begin
			gap = (int'(switch_tab[r][3:0]) + 1) * gap_unit;
			cycle_limit += longint'(frames_tab[r] * (frame_len + gap + 1) * 4);
		end
		for (r = 0; r < n_tests; r++) begin
			test_name = test_tab[r];
			model_start(switch_tab[r]);
			apply_reset(switch_tab[r], bp_tab[r]);
			for (f = 0; f < frames_tab[r]; f++) begin
				check_frame(f);
				model_advance();
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
`default_nettype wire
